//--- design/cache_pkg.sv
// cache_pkg: address split widths, data typedefs and controller state enum
package cache_pkg;

  // address and data widths
  localparam int ADDR_BITS  = 64;
  localparam int LINE_BYTES = 64;
  localparam int WORD_BITS  = 64;

  // 1536 bytes / 64-byte lines / 3 ways
  localparam int NUM_SETS = 8;

  // address split, tag | set | offset
  localparam int OFFSET_BITS = $clog2(LINE_BYTES);
  localparam int SET_BITS    = $clog2(NUM_SETS);
  localparam int TAG_BITS    = ADDR_BITS - SET_BITS - OFFSET_BITS;

  typedef logic [ADDR_BITS-1:0]    addr_t;
  typedef logic [WORD_BITS-1:0]    word_t;
  typedef logic [LINE_BYTES*8-1:0] line_t;
  typedef logic [TAG_BITS-1:0]     tag_t;
  typedef logic [SET_BITS-1:0]     set_t;
  typedef logic [OFFSET_BITS-1:0]  offset_t;  // byte offset, words are 8-byte aligned

  // controller states
  typedef enum logic [2:0] {
    IDLE,           // wait for flush, fill or request
    LOOKUP,         // tag compare, pick next step
    READ_MISS_REQ,  // line read to lower level
    EVICT,          // dirty victim write-back
    INSTALL,        // tag and data write
    RESPOND,        // read-hit word to higher level
    FLUSH           // drop all tags
  } cache_state_t;

endpackage

//--- design/victim_select.sv
// victim_select: per-set round-robin replacement pointer
`timescale 1ns/10ps

module victim_select import cache_pkg::*; #(
  parameter int NUM_WAYS = 3
) (
  input  logic                        clk_in,
  input  logic                        rst_N_in,
  input  set_t                        set,
  input  logic                        advance,     // step pointer of this set
  output logic [$clog2(NUM_WAYS)-1:0] victim_way
);

  localparam int WAY_BITS = $clog2(NUM_WAYS);
  typedef logic [WAY_BITS-1:0] way_idx_t;

  way_idx_t ptr_q [NUM_SETS];  // one pointer per set

  assign victim_way = ptr_q[set];

  // flush leaves the pointers alone
  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      ptr_q <= '{default: '0};
    end else if (advance) begin
      if (ptr_q[set] == way_idx_t'(NUM_WAYS - 1)) ptr_q[set] <= '0;  // wrap
      else ptr_q[set] <= ptr_q[set] + 1'b1;
    end
  end

endmodule

//--- design/tag_store.sv
// tag_store: valid, dirty and tag arrays with hit compare and flush clear
`timescale 1ns/10ps

module tag_store import cache_pkg::*; #(
  parameter int NUM_WAYS = 3
) (
  input  logic                        clk_in,
  input  logic                        rst_N_in,
  input  set_t                        set,
  input  tag_t                        tag,        // tag to compare and to store
  input  logic [$clog2(NUM_WAYS)-1:0] way,        // way for write and readback
  input  logic                        write,
  input  logic                        dirty_in,
  input  logic                        clear_all,  // flush
  output logic                        hit,
  output logic [$clog2(NUM_WAYS)-1:0] hit_way,
  output logic                        way_valid,
  output logic                        way_dirty,
  output tag_t                        way_tag
);

  localparam int WAY_BITS = $clog2(NUM_WAYS);
  typedef logic [WAY_BITS-1:0] way_idx_t;

  logic [NUM_SETS-1:0] valid_q [NUM_WAYS];
  logic [NUM_SETS-1:0] dirty_q [NUM_WAYS];
  tag_t                tag_q   [NUM_WAYS][NUM_SETS];  // meaningless while invalid

  // compare all ways of the set
  // walking down means the lowest matching way is the one kept
  always_comb begin
    hit     = 1'b0;
    hit_way = '0;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (valid_q[w][set] && (tag_q[w][set] == tag)) begin
        hit     = 1'b1;
        hit_way = way_idx_t'(w);
      end
    end
  end

  // readback of the addressed way, used for the victim check
  assign way_valid = valid_q[way][set];
  assign way_dirty = dirty_q[way][set];
  assign way_tag   = tag_q[way][set];

  always_ff @(posedge clk_in) begin
    if (!rst_N_in || clear_all) begin
      valid_q <= '{default: '0};  // dirty data is dropped too
      dirty_q <= '{default: '0};
    end else if (write) begin
      valid_q[way][set] <= 1'b1;
      dirty_q[way][set] <= dirty_in;
    end
  end

  always_ff @(posedge clk_in) begin
    if (write) tag_q[way][set] <= tag;
  end

endmodule

//--- design/data_store.sv
// data_store: line array with word read, word write and line write
`timescale 1ns/10ps

module data_store import cache_pkg::*; #(
  parameter int NUM_WAYS = 3
) (
  input  logic                        clk_in,
  input  set_t                        set,
  input  logic [$clog2(NUM_WAYS)-1:0] way,
  input  offset_t                     offset,
  input  logic                        word_write,  // single word from higher level
  input  word_t                       word_in,
  input  logic                        line_write,  // whole line from lower level
  input  line_t                       line_in,
  output line_t                       line_out,
  output word_t                       word_out
);

  // low offset bits address bytes inside a word
  localparam int BYTE_SEL_BITS = $clog2(WORD_BITS / 8);

  line_t mem_q [NUM_WAYS][NUM_SETS];

  logic [OFFSET_BITS-BYTE_SEL_BITS-1:0] word_idx;  // word within the line

  assign word_idx = offset[OFFSET_BITS-1:BYTE_SEL_BITS];

  assign line_out = mem_q[way][set];
  assign word_out = line_out[word_idx*WORD_BITS +: WORD_BITS];

  always_ff @(posedge clk_in) begin
    if (line_write) begin
      mem_q[way][set] <= line_in;
    end else if (word_write) begin
      mem_q[way][set][word_idx*WORD_BITS +: WORD_BITS] <= word_in;  // rest of line kept
    end
  end

endmodule

//--- design/cache_ctrl.sv
// cache_ctrl: request capture, controller FSM, store strobes and registered level outputs
`timescale 1ns/10ps

module cache_ctrl import cache_pkg::*; #(
  parameter int NUM_WAYS = 3
) (
  input  logic                        clk_in,
  input  logic                        rst_N_in,
  input  logic                        flush_in,
  // higher level
  input  logic                        hc_valid_in,
  input  logic                        hc_we_in,
  input  addr_t                       hc_addr_in,
  input  word_t                       hc_value_in,
  input  logic                        hc_ready_in,
  output logic                        hc_ready_out,   // accept pulse
  output logic                        hc_valid_out,
  output word_t                       hc_value_out,
  // lower level
  input  logic                        lc_valid_in,    // fill
  input  addr_t                       lc_addr_in,
  input  line_t                       lc_value_in,
  input  logic                        lc_ready_in,
  output logic                        lc_ready_out,   // fill accept pulse
  output logic                        lc_valid_out,
  output logic                        we_out,         // high for write-back
  output addr_t                       lc_addr_out,
  output line_t                       lc_value_out,
  // from stores and pointer
  input  logic                        hit,
  input  logic [$clog2(NUM_WAYS)-1:0] hit_way,
  input  logic                        way_valid,
  input  logic                        way_dirty,
  input  tag_t                        way_tag,
  input  logic [$clog2(NUM_WAYS)-1:0] victim_way,
  input  line_t                       line_out,
  input  word_t                       word_out,
  // to stores and pointer
  output set_t                        set,
  output tag_t                        tag,
  output logic [$clog2(NUM_WAYS)-1:0] way,
  output offset_t                     offset,
  output logic                        tag_write,
  output logic                        dirty_in,
  output logic                        clear_all,
  output logic                        word_write,
  output word_t                       word_in,
  output logic                        line_write,
  output line_t                       line_in,
  output logic                        advance
);

  localparam int WAY_BITS = $clog2(NUM_WAYS);
  typedef logic [WAY_BITS-1:0] way_idx_t;

  cache_state_t state, state_d;

  logic     flush_held;  // flush_in already served, wait for it to drop
  logic     take_flush;
  logic     req_fill;    // captured request is a lower-level fill
  logic     req_we;      // captured request is a word write
  logic     is_read;
  logic     miss_r;      // install follows a miss
  way_idx_t way_r;
  way_idx_t lookup_way;

  addr_t req_addr;       // captured payload
  word_t req_word;
  line_t req_line;

  assign take_flush = (state == IDLE) && flush_in && !flush_held;
  assign is_read    = !req_fill && !req_we;

  // address split of the captured request
  assign tag    = req_addr[ADDR_BITS-1 -: TAG_BITS];
  assign set    = req_addr[OFFSET_BITS +: SET_BITS];
  assign offset = req_addr[OFFSET_BITS-1:0];

  // hit way on a hit, else victim, so readbacks show the line to evict
  assign lookup_way = hit ? hit_way : victim_way;
  assign way        = (state == LOOKUP) ? lookup_way : way_r;

  assign tag_write  = (state == INSTALL);
  assign dirty_in   = !req_fill;                     // fills land clean
  assign line_write = (state == INSTALL) && req_fill;
  assign word_write = (state == INSTALL) && !req_fill;
  assign advance    = (state == INSTALL) && miss_r;  // pointer moves on miss installs only
  assign clear_all  = (state == FLUSH);
  assign line_in    = req_line;
  assign word_in    = req_word;

  always_comb begin
    state_d = state;
    case (state)
      IDLE: begin
        if (take_flush) state_d = FLUSH;  // flush, then fill, then request
        else if (lc_valid_in || hc_valid_in) state_d = LOOKUP;
      end
      LOOKUP: begin
        if (hit) state_d = is_read ? RESPOND : INSTALL;
        else if (is_read) state_d = READ_MISS_REQ;
        else if (way_valid && way_dirty) state_d = EVICT;  // write back first
        else state_d = INSTALL;
      end
      READ_MISS_REQ: if (lc_ready_in) state_d = IDLE;  // requester retries after fill
      EVICT:         if (lc_ready_in) state_d = INSTALL;
      RESPOND:       if (hc_ready_in) state_d = IDLE;
      INSTALL:       state_d = IDLE;
      FLUSH:         state_d = IDLE;
      default:       state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      state        <= IDLE;
      flush_held   <= 1'b0;
      req_fill     <= 1'b0;
      req_we       <= 1'b0;
      miss_r       <= 1'b0;
      way_r        <= '0;
      hc_ready_out <= 1'b0;
      lc_ready_out <= 1'b0;
      hc_valid_out <= 1'b0;
      lc_valid_out <= 1'b0;
      we_out       <= 1'b0;
    end else begin
      state      <= state_d;
      flush_held <= flush_in && (flush_held || take_flush);
      // accept pulses, fill wins over request
      lc_ready_out <= (state == IDLE) && !take_flush && lc_valid_in;
      hc_ready_out <= (state == IDLE) && !take_flush && !lc_valid_in && hc_valid_in;
      // levels held for as long as the state lasts
      lc_valid_out <= (state_d == READ_MISS_REQ) || (state_d == EVICT);
      we_out       <= (state_d == EVICT);
      hc_valid_out <= (state_d == RESPOND);
      if ((state == IDLE) && (state_d == LOOKUP)) begin
        req_fill <= lc_valid_in;
        req_we   <= !lc_valid_in && hc_we_in;
      end
      if (state == LOOKUP) begin
        way_r  <= lookup_way;
        miss_r <= !hit;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (state == IDLE) begin  // only the accepted one matters
      req_addr <= lc_valid_in ? lc_addr_in : hc_addr_in;
      req_word <= hc_value_in;
      req_line <= lc_value_in;
    end
    if (state == LOOKUP) begin
      hc_value_out <= word_out;
      lc_value_out <= line_out;  // victim line, don't-care on a read request
      lc_addr_out  <= is_read ? req_addr : {way_tag, set, offset_t'(0)};
    end
  end

endmodule

//--- design/cache_top.sv
// cache_top: set-associative write-back cache, controller wired to stores and pointer
`timescale 1ns/10ps

module cache_top import cache_pkg::*; #(
  parameter int NUM_WAYS = 3
) (
  input  logic  clk_in,
  input  logic  rst_N_in,
  input  logic  flush_in,
  // higher level
  input  logic  hc_valid_in,
  input  logic  hc_we_in,
  input  addr_t hc_addr_in,
  input  word_t hc_value_in,
  input  logic  hc_ready_in,
  output logic  hc_ready_out,
  output logic  hc_valid_out,
  output word_t hc_value_out,
  // lower level
  input  logic  lc_valid_in,
  input  addr_t lc_addr_in,
  input  line_t lc_value_in,
  input  logic  lc_ready_in,
  output logic  lc_ready_out,
  output logic  lc_valid_out,
  output logic  we_out,
  output addr_t lc_addr_out,
  output line_t lc_value_out
);

  localparam int WAY_BITS = $clog2(NUM_WAYS);

  // store interface
  set_t                set;
  tag_t                tag;
  offset_t             offset;
  logic [WAY_BITS-1:0] way;
  logic [WAY_BITS-1:0] hit_way;
  logic [WAY_BITS-1:0] victim_way;
  logic                hit, way_valid, way_dirty;
  tag_t                way_tag;
  logic                tag_write, dirty_in, clear_all;
  logic                word_write, line_write, advance;
  word_t               word_in, word_out;
  line_t               line_in, line_out;

  cache_ctrl #(.NUM_WAYS(NUM_WAYS)) u_ctrl (
    .clk_in, .rst_N_in, .flush_in,
    .hc_valid_in, .hc_we_in, .hc_addr_in, .hc_value_in, .hc_ready_in,
    .hc_ready_out, .hc_valid_out, .hc_value_out,
    .lc_valid_in, .lc_addr_in, .lc_value_in, .lc_ready_in,
    .lc_ready_out, .lc_valid_out, .we_out, .lc_addr_out, .lc_value_out,
    .hit, .hit_way, .way_valid, .way_dirty, .way_tag, .victim_way,
    .line_out, .word_out,
    .set, .tag, .way, .offset, .tag_write, .dirty_in, .clear_all,
    .word_write, .word_in, .line_write, .line_in, .advance
  );

  tag_store #(.NUM_WAYS(NUM_WAYS)) u_tags (
    .clk_in, .rst_N_in,
    .set, .tag, .way,
    .write    (tag_write),
    .dirty_in, .clear_all,
    .hit, .hit_way, .way_valid, .way_dirty, .way_tag
  );

  data_store #(.NUM_WAYS(NUM_WAYS)) u_data (
    .clk_in,
    .set, .way, .offset,
    .word_write, .word_in,
    .line_write, .line_in,
    .line_out, .word_out
  );

  victim_select #(.NUM_WAYS(NUM_WAYS)) u_victim (
    .clk_in, .rst_N_in,
    .set, .advance,
    .victim_way
  );

endmodule

//--- test/tb_clock.sv
// tb_clock: free-running testbench clock and active-low reset generator
`timescale 1ns/10ps

module tb_clock #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 8
) (
  output logic clk,
  output logic rst_N
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  initial begin
    rst_N = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);  // release away from the sampling edge
    rst_N = 1'b1;
  end

endmodule

//--- test/cache_tb.sv
// op table testbench with reference model, handshake tasks, compare tasks and watchdog
`timescale 1ns/10ps

module cache_tb import cache_pkg::*; ();

  localparam int          WAYS          = 3;
  localparam int          PERIOD_NS     = 100;
  localparam int          RESET_CYCLES  = 8;
  localparam int          CYCLES_PER_OP = 40;  // watchdog budget per table entry
  localparam logic [31:0] SEED          = 32'h471d_8b1d;

  typedef enum {OP_READ, OP_WRITE, OP_FILL, OP_FLUSH, OP_PRIO} op_t;

  typedef struct {
    string name;
    op_t   kind;
    addr_t addr;
    line_t data;      // fill line or write word in the low bits
    logic  exp_wb;    // write-back expected before the install
    addr_t wb_addr;
    line_t wb_line;
    logic  exp_hit;   // read served from the cache
    word_t exp_word;
  } entry_t;

  logic  clk_in, rst_N_in, flush_in;
  logic  hc_valid_in, hc_we_in, hc_ready_in, hc_ready_out, hc_valid_out;
  addr_t hc_addr_in;
  word_t hc_value_in, hc_value_out;
  logic  lc_valid_in, lc_ready_in, lc_ready_out, lc_valid_out, we_out;
  addr_t lc_addr_in, lc_addr_out;
  line_t lc_value_in, lc_value_out;

  entry_t tbl [$];
  logic   table_ready = 1'b0;

  // reference model state per way and set
  logic  m_valid [WAYS][NUM_SETS] = '{default: 1'b0};
  logic  m_dirty [WAYS][NUM_SETS] = '{default: 1'b0};
  tag_t  m_tag   [WAYS][NUM_SETS];
  line_t m_line  [WAYS][NUM_SETS];
  int    m_ptr   [NUM_SETS]       = '{default: 0};  // round-robin victim per set

  tb_clock #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(RESET_CYCLES)) u_clock (
    .clk   (clk_in),
    .rst_N (rst_N_in)
  );

  cache_top #(.NUM_WAYS(WAYS)) DUT (
    .clk_in, .rst_N_in, .flush_in,
    .hc_valid_in, .hc_we_in, .hc_addr_in, .hc_value_in, .hc_ready_in,
    .hc_ready_out, .hc_valid_out, .hc_value_out,
    .lc_valid_in, .lc_addr_in, .lc_value_in, .lc_ready_in,
    .lc_ready_out, .lc_valid_out, .we_out, .lc_addr_out, .lc_value_out
  );

  function automatic addr_t make_addr(tag_t t, set_t s, offset_t o);
    return {t, s, o};
  endfunction

  function automatic int word_index(addr_t a);
    return int'(a[OFFSET_BITS-1:$clog2(WORD_BITS/8)]);  // 8-byte words
  endfunction

  // odd multipliers keep every address bit in every word
  function automatic line_t pattern_line(addr_t a);
    line_t l;
    for (int w = 0; w < LINE_BYTES / 8; w++) begin
      l[w*WORD_BITS +: WORD_BITS] = (a * (2 * w + 3)) ^ 64'h5a5a_0f0f_c3c3_9696;
    end
    return l;
  endfunction

  function automatic line_t random_line();
    line_t l;
    for (int i = 0; i < LINE_BYTES / 4; i++) l[i*32 +: 32] = $urandom;
    return l;
  endfunction

  // lowest valid way holding the tag or -1 on a miss
  function automatic int model_lookup(addr_t a);
    set_t s;
    s = a[OFFSET_BITS +: SET_BITS];
    for (int w = 0; w < WAYS; w++) begin
      if (m_valid[w][s] && (m_tag[w][s] == a[ADDR_BITS-1 -: TAG_BITS])) return w;
    end
    return -1;
  endfunction

  function automatic void model_read(int i);
    int w;
    w = model_lookup(tbl[i].addr);
    tbl[i].exp_hit = (w >= 0);
    if (w >= 0) begin
      tbl[i].exp_word = m_line[w][tbl[i].addr[OFFSET_BITS +: SET_BITS]]
                        [word_index(tbl[i].addr)*WORD_BITS +: WORD_BITS];
    end
  endfunction

  function automatic void model_install(int i, logic fill);
    set_t s;
    int   w;
    s = tbl[i].addr[OFFSET_BITS +: SET_BITS];
    w = model_lookup(tbl[i].addr);
    if (w < 0) begin  // miss takes the pointed way and moves the pointer
      w = m_ptr[s];
      m_ptr[s] = (m_ptr[s] + 1) % WAYS;
      if (m_valid[w][s] && m_dirty[w][s]) begin
        tbl[i].exp_wb  = 1'b1;
        tbl[i].wb_addr = {m_tag[w][s], s, offset_t'(0)};
        tbl[i].wb_line = m_line[w][s];
      end
    end
    m_valid[w][s] = 1'b1;
    m_dirty[w][s] = !fill;  // fills land clean and word writes dirty
    m_tag[w][s]   = tbl[i].addr[ADDR_BITS-1 -: TAG_BITS];
    if (fill) m_line[w][s] = tbl[i].data;
    else m_line[w][s][word_index(tbl[i].addr)*WORD_BITS +: WORD_BITS] = tbl[i].data[63:0];
  endfunction

  task automatic add_op(string name, op_t kind, addr_t addr, line_t data);
    tbl.push_back('{name, kind, addr, data, 1'b0, '0, '0, 1'b0, '0});
  endtask

  task automatic build_table();
    line_t ra, rb, rc;
    ra = random_line();
    rb = random_line();
    rc = random_line();
    add_op("rd_miss_a", OP_READ, make_addr(1, 2, 'h18), '0);
    add_op("fill_a", OP_FILL, make_addr(1, 2, 'h00), ra);
    add_op("rd_retry_a", OP_READ, make_addr(1, 2, 'h18), '0);
    add_op("wr_hit_a", OP_WRITE, make_addr(1, 2, 'h08), line_t'(64'hdead_beef_0123_4567));
    add_op("rd_new_word", OP_READ, make_addr(1, 2, 'h08), '0);
    add_op("rd_old_word", OP_READ, make_addr(1, 2, 'h18), '0);
    for (int t = 10; t < 10 + WAYS + 1; t++) begin  // one more line than ways in set 5
      add_op($sformatf("fill_s5_t%0d", t), OP_FILL, make_addr(t, 5, 0),
             pattern_line(make_addr(t, 5, 0)));
    end
    add_op("rd_s5_first_gone", OP_READ, make_addr(10, 5, 'h20), '0);
    add_op("rd_s5_last", OP_READ, make_addr(13, 5, 'h38), '0);
    add_op("fill_t2", OP_FILL, make_addr(2, 2, 0), pattern_line(make_addr(2, 2, 0)));
    add_op("fill_t3", OP_FILL, make_addr(3, 2, 0), rb);
    add_op("wr_miss_evict_a", OP_WRITE, make_addr(4, 2, 'h28), line_t'(64'h0bad_cafe_f00d_0042));
    add_op("wr_hit_t2", OP_WRITE, make_addr(2, 2, 'h10), line_t'(64'h7777_1111_2222_3333));
    add_op("fill_evict_t2", OP_FILL, make_addr(5, 2, 0), pattern_line(make_addr(5, 2, 0)));
    add_op("rd_t4_written", OP_READ, make_addr(4, 2, 'h28), '0);
    // dirty line in the way the next set 2 miss will pick
    add_op("wr_hit_t3", OP_WRITE, make_addr(3, 2, 'h18), line_t'(64'h3333_aaaa_5555_cccc));
    add_op("flush", OP_FLUSH, '0, '0);
    add_op("rd_t4_flushed", OP_READ, make_addr(4, 2, 'h28), '0);
    add_op("rd_t11_flushed", OP_READ, make_addr(11, 5, 'h00), '0);
    add_op("wr_after_flush", OP_WRITE, make_addr(6, 2, 'h00), line_t'(64'h1234_5678_9abc_def0));
    add_op("prio_fill_read", OP_PRIO, make_addr(7, 3, 'h30), rc);
  endtask

  task automatic stop_on_error(string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_word(string name, word_t exp, word_t act);
    if (act !== exp) stop_on_error($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_addr(string name, addr_t exp, addr_t act);
    if (act !== exp) stop_on_error($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_line(string name, line_t exp, line_t act);
    if (act !== exp) stop_on_error($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    if (act !== exp) stop_on_error($sformatf("MISMATCH %s expected %b actual %b", name, exp, act));
  endtask

  task automatic start_request(addr_t a, logic we, word_t v);
    hc_valid_in = 1'b1;
    hc_we_in    = we;
    hc_addr_in  = a;
    hc_value_in = v;
  endtask

  task automatic start_fill(addr_t a, line_t l);
    lc_valid_in = 1'b1;
    lc_addr_in  = a;
    lc_value_in = l;
  endtask

  task automatic await_request_accept();
    do @(negedge clk_in); while (!hc_ready_out);
    hc_valid_in = 1'b0;
  endtask

  // a fill must be taken before any pending request
  task automatic await_fill_accept(string name);
    do begin
      @(negedge clk_in);
      check_flag({name, " request taken before fill"}, 1'b0, hc_ready_out);
    end while (!lc_ready_out);
    lc_valid_in = 1'b0;
  endtask

  task automatic answer_lower();
    lc_ready_in = 1'b1;
    do @(negedge clk_in); while (lc_valid_out);  // done when the level drops
    lc_ready_in = 1'b0;
  endtask

  task automatic finish_install(entry_t e);
    @(negedge clk_in);  // after the one LOOKUP cycle a write-back is visible
    check_flag({e.name, " write-back"}, e.exp_wb, lc_valid_out);
    if (e.exp_wb) begin
      check_flag({e.name, " we_out"}, 1'b1, we_out);
      check_addr({e.name, " wb addr"}, e.wb_addr, lc_addr_out);
      check_line({e.name, " wb line"}, e.wb_line, lc_value_out);
      answer_lower();
    end
  endtask

  task automatic finish_read(entry_t e);
    do @(negedge clk_in); while (!hc_valid_out && !lc_valid_out);
    check_flag({e.name, " hit"}, e.exp_hit, hc_valid_out);
    if (e.exp_hit) begin
      check_word({e.name, " word"}, e.exp_word, hc_value_out);
      hc_ready_in = 1'b1;
      do @(negedge clk_in); while (hc_valid_out);
      hc_ready_in = 1'b0;
    end else begin
      check_flag({e.name, " we_out"}, 1'b0, we_out);
      check_addr({e.name, " req addr"}, e.addr, lc_addr_out);
      answer_lower();
    end
  endtask

  task automatic apply_op(entry_t e);
    case (e.kind)
      OP_READ: begin
        start_request(e.addr, 1'b0, '0);
        await_request_accept();
        finish_read(e);
      end
      OP_WRITE: begin
        start_request(e.addr, 1'b1, e.data[WORD_BITS-1:0]);
        await_request_accept();
        finish_install(e);
      end
      OP_FILL: begin
        start_fill(e.addr, e.data);
        await_fill_accept(e.name);
        finish_install(e);
      end
      OP_FLUSH: begin
        flush_in = 1'b1;
        repeat (4) begin  // last install tail plus the FLUSH cycle
          @(negedge clk_in);
          check_flag({e.name, " write-back"}, 1'b0, lc_valid_out);  // dirty lines dropped
        end
        flush_in = 1'b0;
        @(negedge clk_in);
      end
      OP_PRIO: begin  // fill and read raised in the same cycle
        start_fill(e.addr, e.data);
        start_request(e.addr, 1'b0, '0);
        await_fill_accept(e.name);
        finish_install(e);
        await_request_accept();
        finish_read(e);
      end
    endcase
  endtask

  initial begin
    flush_in    = 1'b0;
    hc_valid_in = 1'b0;
    hc_we_in    = 1'b0;
    hc_addr_in  = '0;
    hc_value_in = '0;
    hc_ready_in = 1'b0;
    lc_valid_in = 1'b0;
    lc_addr_in  = '0;
    lc_value_in = '0;
    lc_ready_in = 1'b0;
    void'($urandom(SEED));
    build_table();
    foreach (tbl[i]) begin  // expected values in table order
      case (tbl[i].kind)
        OP_READ:  model_read(i);
        OP_WRITE: model_install(i, 1'b0);
        OP_FILL:  model_install(i, 1'b1);
        OP_FLUSH: begin
          m_valid = '{default: 1'b0};  // dirty data dropped and pointers kept
          m_dirty = '{default: 1'b0};
        end
        OP_PRIO: begin
          model_install(i, 1'b1);
          model_read(i);
        end
      endcase
    end
    table_ready = 1'b1;
    @(posedge rst_N_in);
    @(negedge clk_in);
    foreach (tbl[i]) apply_op(tbl[i]);
    $display(">>> PASS");
    $finish;
  end

  // watchdog
  initial begin
    wait (table_ready);
    #((tbl.size() * CYCLES_PER_OP + RESET_CYCLES) * PERIOD_NS);
    stop_on_error("timeout: the cache did not finish the table within its cycle budget");
  end

endmodule

//--- list.f
design/cache_pkg.sv
design/victim_select.sv
design/tag_store.sv
design/data_store.sv
design/cache_ctrl.sv
design/cache_top.sv
test/tb_clock.sv
test/cache_tb.sv

//--- Bender.yml
package:
  name: cache

sources:
  - files:
      - design/cache_pkg.sv
      - design/victim_select.sv
      - design/tag_store.sv
      - design/data_store.sv
      - design/cache_ctrl.sv
      - design/cache_top.sv
  - target: test
    files:
      - test/tb_clock.sv
      - test/cache_tb.sv
